// ==== all.f ====
+incdir+logic
logic/ctrlPkg.sv
logic/stageCtrlIf.sv
logic/instrDecoder.sv
logic/executeCtrl.sv
logic/memWbCtrl.sv
logic/controller.sv
verification/controllerTb.sv

// ==== build.sh ====
#!/bin/sh
# Compile the controller testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timescale 1ns/1ps -f all.f --top-module controllerTb \
  --Mdir "$OBJ" -o controllerTbSim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$OBJ/controllerTbSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== logic/controller.sv ====
// Pipelined instruction control unit, top level
// Decoder, Execute control and Memory/Writeback control
// joined through the stage control interfaces

`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module controller (
  input  logic                  clk,
  input  logic                  rst,
  // Decode
  input  logic [`INSTR_W-1:0]   instrD,
  input  logic                  stallD, flushD,
  output ctrlPkg::immSrcT       immSrcD,
  output logic                  illegalInstrD,
  output logic                  jumpD, branchD,
  output logic                  storeStallD,   // To hazard unit
  output logic                  instrValidD,
  // Execute
  input  logic [1:0]            flagsE,        // {eq, lt}
  input  logic                  stallE, flushE,
  output logic                  pcSrcE,
  output logic [`ALUCTRL_W-1:0] aluControlE,
  output logic                  aluSrcAE, aluSrcBE,
  output logic                  aluResultSrcE,
  output logic                  memReadE, csrReadE,
  output logic [`FUNCT3_W-1:0]  funct3E,
  output logic                  branchSignedE,
  output logic                  instrValidE,
  // Memory
  input  logic                  stallM, flushM,
  output logic [`MEMRW_W-1:0]   memRWM,
  output logic                  csrReadM, csrWriteM, privilegedM,
  output logic [`FUNCT3_W-1:0]  funct3M,
  output logic                  regWriteM,
  output logic                  instrValidM,
  // Writeback
  input  logic                  stallW, flushW,
  output logic                  regWriteW,
  output ctrlPkg::resultSrcT    resultSrcW
);

  decodeCtrlIf deIf ();  // Decode to Execute bundle
  execCtrlIf   emIf ();  // Execute to Memory bundle

  instrDecoder decoder_inst (.instrD, .immSrcD, .illegalInstrD, .jumpD, .branchD, .deIf);

  executeCtrl executeCtrl_inst (
    .clk, .rst, .stallD, .flushD, .stallE, .flushE, .flagsE, .deIf, .emIf,
    .instrValidD, .pcSrcE, .aluControlE, .aluSrcAE, .aluSrcBE, .aluResultSrcE,
    .memReadE, .csrReadE, .funct3E, .branchSignedE, .instrValidE, .storeStallD
  );

  memWbCtrl memWbCtrl_inst (
    .clk, .rst, .stallM, .flushM, .stallW, .flushW, .emIf,
    .memRWM, .csrReadM, .csrWriteM, .privilegedM, .funct3M, .regWriteM, .instrValidM,
    .regWriteW, .resultSrcW
  );
endmodule

`default_nettype wire

// ==== logic/ctrlPkg.sv ====
// Control unit types
// Opcode map of the base integer set
// Immediate format and writeback result source encodings

`default_nettype none

`include "ctrl_consts.svh"

package ctrlPkg;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////
  typedef enum logic [`OPCODE_W-1:0] {
    load   = 7'b0000011, // lb lh lw lbu lhu
    opImm  = 7'b0010011, // Register-immediate ALU
    auipc  = 7'b0010111,
    store  = 7'b0100011, // sb sh sw
    op     = 7'b0110011, // Register-register ALU
    lui    = 7'b0110111,
    branch = 7'b1100011,
    jalr   = 7'b1100111,
    jal    = 7'b1101111,
    system = 7'b1110011  // CSR access and privileged ops
  } opcodeT;

  // Immediate extension format, matches the datapath extender
  typedef enum logic [2:0] {
    immI = 3'b000,
    immS = 3'b001,
    immB = 3'b010,
    immJ = 3'b011,
    immU = 3'b100        // lui and auipc
  } immSrcT;

  // Writeback source select
  typedef enum logic [2:0] {
    resAlu = 3'b000,
    resMem = 3'b001,     // Load data
    resCsr = 3'b010      // CSR read data
  } resultSrcT;

endpackage

`default_nettype wire

// ==== logic/ctrl_consts.svh ====
// Control unit constants
// Instruction field widths and bit positions
// Memory read/write pair and ALU control widths

`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

//////////////////////////////
// Instruction fields
//////////////////////////////
`define INSTR_W 32     // RV32I instruction word
`define OPCODE_W 7     // Major opcode, bits 6..0
`define FUNCT3_W 3     // Minor opcode
`define FUNCT7_W 7     // Upper function field
`define RS1_W 5        // Source register / CSR uimm

`define FUNCT3_LSB 12  // Lowest bit of funct3
`define RS1_LSB 15     // Lowest bit of rs1 and uimm
`define FUNCT7_LSB 25  // Lowest bit of funct7

//////////////////////////////
// Control bundles
//////////////////////////////
`define MEMRW_W 2      // Upper bit read, lower bit write
`define ALUCTRL_W 2    // {subArith, aluOp}

`endif

// ==== logic/executeCtrl.sv ====
// Decode valid register and Execute control register
// Branch resolution from the comparator flags
// Store stall for a memory access right behind a store

`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module executeCtrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stallD, flushD,
  input  logic                  stallE, flushE,
  input  logic [1:0]            flagsE,        // {eq, lt}
  decodeCtrlIf.execute          deIf,
  execCtrlIf.execute            emIf,
  output logic                  instrValidD,
  output logic                  pcSrcE,
  output logic [`ALUCTRL_W-1:0] aluControlE,
  output logic                  aluSrcAE, aluSrcBE,
  output logic                  aluResultSrcE,
  output logic                  memReadE, csrReadE,
  output logic [`FUNCT3_W-1:0]  funct3E,
  output logic                  branchSignedE,
  output logic                  instrValidE,
  output logic                  storeStallD
);
  import ctrlPkg::*;

  localparam int CtrlEW = 1 + $bits(resultSrcT) + `MEMRW_W + 2 + `ALUCTRL_W + 6
                        + `FUNCT3_W + 1;

  logic [CtrlEW-1:0]             ctrlDIn, ctrlE;
  logic                          regWriteE, jumpE, branchE;
  logic [$bits(resultSrcT)-1:0]  resultSrcE;
  logic [`MEMRW_W-1:0]           memRWE;     // {read, write}
  logic                          csrWriteE, privilegedE;
  logic                          eqE, ltE, branchFlagE, branchTakenE;

  // Decode valid bit, set by the first unstalled edge after reset
  always_ff @(posedge clk) begin
    if (rst) instrValidD <= 1'b0;
    else if (!stallD) instrValidD <= ~flushD;
  end

  //////////////////////////////
  // Execute control register
  //////////////////////////////
  assign ctrlDIn = {deIf.regWrite, deIf.resultSrc, deIf.memRW, deIf.jump, deIf.branch,
                    deIf.aluControl, deIf.aluSrcA, deIf.aluSrcB, deIf.aluResultSrc,
                    deIf.csrRead, deIf.csrWrite, deIf.privileged, deIf.funct3, instrValidD};

  always_ff @(posedge clk) begin
    if (rst) ctrlE <= '0;
    else if (!stallE) ctrlE <= flushE ? '0 : ctrlDIn; // Hold while stalled
  end

  assign {regWriteE, resultSrcE, memRWE, jumpE, branchE, aluControlE, aluSrcAE, aluSrcBE,
          aluResultSrcE, csrReadE, csrWriteE, privilegedE, funct3E, instrValidE} = ctrlE;

  //////////////////////////////
  // Branch resolution
  //////////////////////////////
  assign {eqE, ltE}    = flagsE;
  assign branchFlagE   = funct3E[2] ? ltE : eqE;       // beq/bne vs blt/bge family
  assign branchTakenE  = branchFlagE ^ funct3E[0];     // Odd funct3 inverts
  assign pcSrcE        = jumpE | (branchE & branchTakenE);
  assign branchSignedE = branchE & (funct3E[2:1] != 2'b11); // bltu/bgeu unsigned

  assign memReadE    = memRWE[1];
  assign storeStallD = memRWE[0] & (|deIf.memRW); // Load or store behind a store

  // On to Memory
  assign emIf.regWrite   = regWriteE;
  assign emIf.resultSrc  = resultSrcT'(resultSrcE);
  assign emIf.memRW      = memRWE;
  assign emIf.csrRead    = csrReadE;
  assign emIf.csrWrite   = csrWriteE;
  assign emIf.privileged = privilegedE;
  assign emIf.funct3     = funct3E;
  assign emIf.instrValid = instrValidE;
endmodule

`default_nettype wire

// ==== logic/instrDecoder.sv ====
// Decode-stage instruction decoder
// Main decoder with strict funct3/funct7 legality checks
// ALU decoder for add/sub, sra, slt and sltu
// CSR write rule for set and clear forms with a zero source

`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module instrDecoder (
  input  logic [`INSTR_W-1:0] instrD,
  output ctrlPkg::immSrcT     immSrcD,
  output logic                illegalInstrD,
  output logic                jumpD,
  output logic                branchD,
  decodeCtrlIf.decoder        deIf
);
  import ctrlPkg::*;

  opcodeT               opD;
  logic [`FUNCT3_W-1:0] funct3D;
  logic [`FUNCT7_W-1:0] funct7D;
  logic [`RS1_W-1:0]    rs1D;

  logic funct7ZeroD, funct7AltD;           // 0000000 and 0100000
  logic immLegalD, regLegalD;              // opImm and op encodings
  logic loadLegalD, storeLegalD;
  logic branchLegalD, jalrLegalD;

  logic                regWriteD;
  logic                aluSrcAD, aluSrcBD;
  logic [`MEMRW_W-1:0] memRWD;
  resultSrcT           resultSrcD;
  logic                aluOpD, aluResultSrcD;
  logic                csrReadD, privilegedD;
  logic                subD, sraD, sltD, sltuD, subArithD;
  logic                csrZeroSrcD;

  // Field extraction
  assign opD     = opcodeT'(instrD[`OPCODE_W-1:0]);
  assign funct3D = instrD[`FUNCT3_LSB +: `FUNCT3_W];
  assign funct7D = instrD[`FUNCT7_LSB +: `FUNCT7_W];
  assign rs1D    = instrD[`RS1_LSB +: `RS1_W];

  //////////////////////////////
  // Legality checks
  //////////////////////////////
  assign funct7ZeroD  = (funct7D == 7'b0000000);
  assign funct7AltD   = (funct7D == 7'b0100000);  // sub, sra, srai
  assign immLegalD    = ((funct3D != 3'd1) && (funct3D != 3'd5))    // Non-shift immediates
                      | ((funct3D == 3'd1) & funct7ZeroD)            // slli
                      | ((funct3D == 3'd5) & (funct7ZeroD | funct7AltD));
  assign regLegalD    = funct7ZeroD | (funct7AltD & ((funct3D == 3'd0) | (funct3D == 3'd5)));
  assign loadLegalD   = (funct3D <= 3'd2) | (funct3D == 3'd4) | (funct3D == 3'd5);
  assign storeLegalD  = (funct3D <= 3'd2);        // sb sh sw
  assign branchLegalD = (funct3D[2:1] != 2'b01);  // No funct3 2 or 3
  assign jalrLegalD   = (funct3D == 3'd0);

  //////////////////////////////
  // Main decoder
  //////////////////////////////
  always_comb begin
    regWriteD     = 1'b0;        // Illegal until an opcode matches
    immSrcD       = immI;
    aluSrcAD      = 1'b0;
    aluSrcBD      = 1'b0;
    memRWD        = '0;
    resultSrcD    = resAlu;
    branchD       = 1'b0;
    aluOpD        = 1'b0;
    jumpD         = 1'b0;
    aluResultSrcD = 1'b0;
    csrReadD      = 1'b0;
    privilegedD   = 1'b0;
    illegalInstrD = 1'b1;
    case (opD)
      load: if (loadLegalD) begin
        regWriteD = 1'b1; aluSrcBD = 1'b1; illegalInstrD = 1'b0;
        memRWD = 2'b10;                  // Read
        resultSrcD = resMem;
      end
      opImm: if (immLegalD) begin
        regWriteD = 1'b1; aluSrcBD = 1'b1; aluOpD = 1'b1; illegalInstrD = 1'b0;
      end
      auipc: begin
        regWriteD = 1'b1; immSrcD = immU; illegalInstrD = 1'b0;
        aluSrcAD = 1'b1; aluSrcBD = 1'b1; // PC plus upper immediate
      end
      store: if (storeLegalD) begin
        immSrcD = immS; aluSrcBD = 1'b1; illegalInstrD = 1'b0;
        memRWD = 2'b01;                  // Write
      end
      op: if (regLegalD) begin
        regWriteD = 1'b1; aluOpD = 1'b1; illegalInstrD = 1'b0;
      end
      lui: begin
        regWriteD = 1'b1; immSrcD = immU; aluSrcBD = 1'b1; illegalInstrD = 1'b0;
        aluResultSrcD = 1'b1;            // Immediate passes straight through
      end
      branch: if (branchLegalD) begin
        immSrcD = immB; aluSrcAD = 1'b1; aluSrcBD = 1'b1; illegalInstrD = 1'b0;
        branchD = 1'b1;                  // Target from PC plus offset
      end
      jalr: if (jalrLegalD) begin
        regWriteD = 1'b1; aluSrcBD = 1'b1; illegalInstrD = 1'b0;
        jumpD = 1'b1; aluResultSrcD = 1'b1; // rd gets PC+4
      end
      jal: begin
        regWriteD = 1'b1; immSrcD = immJ; illegalInstrD = 1'b0;
        aluSrcAD = 1'b1; aluSrcBD = 1'b1; jumpD = 1'b1; aluResultSrcD = 1'b1;
      end
      system: begin
        illegalInstrD = 1'b0;
        if (funct3D == 3'd0) begin
          privilegedD = 1'b1;            // ecall, ebreak, mret and friends
        end else begin
          regWriteD = 1'b1; csrReadD = 1'b1;
          resultSrcD = resCsr;
        end
      end
      default: illegalInstrD = 1'b1;     // Unknown opcode
    endcase
  end

  //////////////////////////////
  // ALU decoder and CSR rule
  //////////////////////////////
  assign subD      = (opD == op) & (funct3D == 3'd0) & funct7D[5]; // Not addi
  assign sraD      = (funct3D == 3'd5) & funct7D[5];               // sra and srai
  assign sltD      = (funct3D == 3'd2);
  assign sltuD     = (funct3D == 3'd3);
  assign subArithD = aluOpD & (subD | sraD | sltD | sltuD);

  // csrrs/csrrc with x0 and csrrsi/csrrci with zero uimm read only
  assign csrZeroSrcD = (rs1D == '0);
  assign deIf.csrWrite = csrReadD & ~(csrZeroSrcD & funct3D[1]);

  assign deIf.regWrite     = regWriteD;
  assign deIf.resultSrc    = resultSrcD;
  assign deIf.memRW        = memRWD;
  assign deIf.jump         = jumpD;
  assign deIf.branch       = branchD;
  assign deIf.aluSrcA      = aluSrcAD;
  assign deIf.aluSrcB      = aluSrcBD;
  assign deIf.aluResultSrc = aluResultSrcD;
  assign deIf.aluControl   = {subArithD, aluOpD};
  assign deIf.csrRead      = csrReadD;
  assign deIf.privileged   = privilegedD;
  assign deIf.funct3       = funct3D;
endmodule

`default_nettype wire

// ==== logic/memWbCtrl.sv ====
// Memory and Writeback control registers
// Each register has its own stall and flush

`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module memWbCtrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stallM, flushM,
  input  logic                 stallW, flushW,
  execCtrlIf.memory            emIf,
  output logic [`MEMRW_W-1:0]  memRWM,       // {read, write}
  output logic                 csrReadM, csrWriteM, privilegedM,
  output logic [`FUNCT3_W-1:0] funct3M,
  output logic                 regWriteM,
  output logic                 instrValidM,
  output logic                 regWriteW,
  output ctrlPkg::resultSrcT   resultSrcW
);
  import ctrlPkg::*;

  localparam int CtrlMW = 1 + $bits(resultSrcT) + `MEMRW_W + 3 + `FUNCT3_W + 1;
  localparam int CtrlWW = 1 + $bits(resultSrcT);

  logic [CtrlMW-1:0]            ctrlEIn, ctrlM;
  logic [CtrlWW-1:0]            ctrlW;
  logic [$bits(resultSrcT)-1:0] resultSrcM, resultSrcBitsW;

  //////////////////////////////
  // Memory control register
  //////////////////////////////
  assign ctrlEIn = {emIf.regWrite, emIf.resultSrc, emIf.memRW, emIf.csrRead, emIf.csrWrite,
                    emIf.privileged, emIf.funct3, emIf.instrValid};

  always_ff @(posedge clk) begin
    if (rst) ctrlM <= '0;
    else if (!stallM) ctrlM <= flushM ? '0 : ctrlEIn; // Flush ignored while stalled
  end

  assign {regWriteM, resultSrcM, memRWM, csrReadM, csrWriteM, privilegedM, funct3M,
          instrValidM} = ctrlM;

  //////////////////////////////
  // Writeback control register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) ctrlW <= '0;
    else if (!stallW) ctrlW <= flushW ? '0 : {regWriteM, resultSrcM};
  end

  assign {regWriteW, resultSrcBitsW} = ctrlW;
  assign resultSrcW = resultSrcT'(resultSrcBitsW); // Result mux select
endmodule

`default_nettype wire

// ==== logic/stageCtrlIf.sv ====
// Pipeline control bundles
// decodeCtrlIf carries Decode control bits into the Execute register
// execCtrlIf carries Execute control bits into the Memory register

`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

interface decodeCtrlIf;
  logic                  regWrite;     // Writes rd
  ctrlPkg::resultSrcT    resultSrc;
  logic [`MEMRW_W-1:0]   memRW;        // {read, write}
  logic                  jump;
  logic                  branch;
  logic                  aluSrcA;      // PC as operand A
  logic                  aluSrcB;      // Immediate as operand B
  logic                  aluResultSrc; // Bypass ALU result
  logic [`ALUCTRL_W-1:0] aluControl;   // {subArith, aluOp}
  logic                  csrRead;
  logic                  csrWrite;
  logic                  privileged;
  logic [`FUNCT3_W-1:0]  funct3;

  modport decoder (output regWrite, resultSrc, memRW, jump, branch, aluSrcA, aluSrcB,
                   aluResultSrc, aluControl, csrRead, csrWrite, privileged, funct3);
  modport execute (input regWrite, resultSrc, memRW, jump, branch, aluSrcA, aluSrcB,
                   aluResultSrc, aluControl, csrRead, csrWrite, privileged, funct3);
endinterface

interface execCtrlIf;
  logic                 regWrite;
  ctrlPkg::resultSrcT   resultSrc;
  logic [`MEMRW_W-1:0]  memRW;
  logic                 csrRead;
  logic                 csrWrite;
  logic                 privileged;
  logic [`FUNCT3_W-1:0] funct3;       // Access size for the LSU
  logic                 instrValid;

  modport execute (output regWrite, resultSrc, memRW, csrRead, csrWrite, privileged, funct3,
                   instrValid);
  modport memory (input regWrite, resultSrc, memRW, csrRead, csrWrite, privileged, funct3,
                  instrValid);
endinterface

`default_nettype wire

// ==== verification/controllerTb.sv ====
// Directed testbench for the pipelined control unit
// Clock, reset, check task and six test tasks
// Reference values come from the RV32I decode and pipeline rules

`timescale 1ns/1ps
`default_nettype none

`include "ctrl_consts.svh"

module controllerTb;
  import ctrlPkg::*;

  localparam logic [`INSTR_W-1:0] Nop = 32'h0000_0013; // addi x0, x0, 0

  logic                  clk, rst;
  logic [`INSTR_W-1:0]   instrD;
  logic                  stallD, flushD, stallE, flushE;
  logic                  stallM, flushM, stallW, flushW;
  logic [1:0]            flagsE;                       // {eq, lt}
  immSrcT                immSrcD;
  logic                  illegalInstrD, jumpD, branchD, storeStallD, instrValidD;
  logic                  pcSrcE, aluSrcAE, aluSrcBE, aluResultSrcE;
  logic [`ALUCTRL_W-1:0] aluControlE;
  logic                  memReadE, csrReadE, branchSignedE, instrValidE;
  logic [`FUNCT3_W-1:0]  funct3E, funct3M;
  logic [`MEMRW_W-1:0]   memRWM;
  logic                  csrReadM, csrWriteM, privilegedM, regWriteM, instrValidM;
  logic                  regWriteW;
  resultSrcT             resultSrcW;

  integer seed = 94;
  int     errCount = 0;
  int     checkCount = 0;
  int     testCount = 0;

  controller controller_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                             // 20 ns period
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    checkCount++;
    if (actual !== expected) begin
      errCount++;
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic stepEdge();
    @(posedge clk);
    @(negedge clk);                                     // Back on the drive edge
  endtask

  task automatic reportTest(input string name, input int errsBefore);
    testCount++;
    if (errCount == errsBefore) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errCount - errsBefore);
  endtask

  function automatic logic [31:0] encInstr(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  // Decode reference from the RV32I encoding rules
  function automatic void expectDecode(input logic [31:0] ins, output immSrcT imm,
                                       output logic jump, output logic br,
                                       output logic illegal);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       legal;
    opc = ins[6:0];
    f3 = ins[`FUNCT3_LSB +: `FUNCT3_W];
    f7 = ins[`FUNCT7_LSB +: `FUNCT7_W];
    imm = immI;
    jump = 1'b0;
    br = 1'b0;
    legal = 1'b1;
    case (opc)
      load:   legal = !(f3 == 3'd3 || f3 >= 3'd6);
      opImm:  if (f3 == 3'd1) legal = (f7 == 7'h00);
              else if (f3 == 3'd5) legal = (f7 == 7'h00 || f7 == 7'h20);
      auipc, lui: imm = immU;
      store: begin
        legal = (f3 < 3'd3);
        imm = immS;
      end
      op:     legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      branch: begin
        legal = (f3 != 3'd2 && f3 != 3'd3);
        imm = immB;
        br = 1'b1;
      end
      jalr: begin
        legal = (f3 == 3'd0);
        jump = 1'b1;
      end
      jal: begin
        imm = immJ;
        jump = 1'b1;
      end
      system: legal = 1'b1;
      default: legal = 1'b0;                            // Unknown opcode
    endcase
    if (!legal) begin
      imm = immI;                                       // Everything zeroed
      jump = 1'b0;
      br = 1'b0;
    end
    illegal = !legal;
  endfunction

  task automatic decodeOne(input logic [31:0] ins, input string name);
    immSrcT expImm;
    logic   expJump, expBranch, expIllegal;
    expectDecode(ins, expImm, expJump, expBranch, expIllegal);
    instrD = ins;
    #1;
    checkEq(32'(immSrcD), 32'(expImm), {name, " immSrcD"});
    checkEq(32'(jumpD), 32'(expJump), {name, " jumpD"});
    checkEq(32'(branchD), 32'(expBranch), {name, " branchD"});
    checkEq(32'(illegalInstrD), 32'(expIllegal), {name, " illegalInstrD"});
    @(negedge clk);
  endtask

  // One instruction through Execute, Memory and Writeback without stalls
  task automatic pushThrough(input string name, input logic [31:0] ins,
                             input logic [1:0] expAlu, input logic expSrcA, input logic expSrcB,
                             input logic expAluRes,
                             input logic [1:0] expMemRW, input logic expRegWrite,
                             input logic expCsrRead, input logic expCsrWrite,
                             input logic expPriv, input resultSrcT expRes);
    instrD = ins;
    stepEdge();                                         // Execute
    instrD = Nop;
    checkEq(32'(aluControlE), 32'(expAlu), {name, " aluControlE"});
    checkEq(32'(aluSrcAE), 32'(expSrcA), {name, " aluSrcAE"});
    checkEq(32'(aluSrcBE), 32'(expSrcB), {name, " aluSrcBE"});
    checkEq(32'(aluResultSrcE), 32'(expAluRes), {name, " aluResultSrcE"});
    checkEq(32'(funct3E), 32'(ins[`FUNCT3_LSB +: `FUNCT3_W]), {name, " funct3E"});
    checkEq(32'(memReadE), 32'(expMemRW[1]), {name, " memReadE"});
    checkEq(32'(csrReadE), 32'(expCsrRead), {name, " csrReadE"});
    checkEq(32'(instrValidE), 32'd1, {name, " instrValidE"});
    stepEdge();                                         // Memory
    checkEq(32'(memRWM), 32'(expMemRW), {name, " memRWM"});
    checkEq(32'(regWriteM), 32'(expRegWrite), {name, " regWriteM"});
    checkEq(32'(csrReadM), 32'(expCsrRead), {name, " csrReadM"});
    checkEq(32'(csrWriteM), 32'(expCsrWrite), {name, " csrWriteM"});
    checkEq(32'(privilegedM), 32'(expPriv), {name, " privilegedM"});
    checkEq(32'(funct3M), 32'(ins[`FUNCT3_LSB +: `FUNCT3_W]), {name, " funct3M"});
    checkEq(32'(instrValidM), 32'd1, {name, " instrValidM"});
    stepEdge();                                         // Writeback
    checkEq(32'(regWriteW), 32'(expRegWrite), {name, " regWriteW"});
    checkEq(32'(resultSrcW), 32'(expRes), {name, " resultSrcW"});
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////
  task automatic resetTest();
    int errs;
    int waited;
    errs = errCount;
    checkEq(32'(instrValidD), 32'd0, "reset instrValidD");
    checkEq(32'(instrValidE), 32'd0, "reset instrValidE");
    checkEq(32'(instrValidM), 32'd0, "reset instrValidM");
    checkEq(32'(regWriteM), 32'd0, "reset regWriteM");
    checkEq(32'(regWriteW), 32'd0, "reset regWriteW");
    checkEq(32'(memRWM), 32'd0, "reset memRWM");
    checkEq(32'(csrWriteM), 32'd0, "reset csrWriteM");
    checkEq(32'(pcSrcE), 32'd0, "reset pcSrcE");
    waited = 0;
    while (!instrValidD && waited < 20) begin           // First unstalled edge
      stepEdge();
      waited++;
    end
    if (!instrValidD) begin
      $display("Timeout: instrValidD never rose after reset");
      errCount++;
    end
    reportTest("reset", errs);
  endtask

  task automatic decodeTableTest();
    int errs;
    logic [6:0] opList [0:10];
    logic [6:0] opc;
    logic [6:0] f7;
    logic [4:0] rs1, rs2, rd;
    logic [2:0] f3;
    logic [1:0] sel;
    errs = errCount;
    opList = '{load, opImm, auipc, store, op, lui, branch, jalr, jal, system, 7'b0001011};
    for (int i = 0; i < 88; i++) begin
      opc = opList[i % 11];                             // Every opcode, random fields
      f3 = 3'($random(seed));
      sel = 2'($random(seed));
      f7 = (sel == 2'd0) ? 7'h00 : (sel == 2'd1) ? 7'h20 : 7'($random(seed));
      rs1 = 5'($random(seed));
      rs2 = 5'($random(seed));
      rd = 5'($random(seed));
      decodeOne(encInstr(f7, rs2, rs1, f3, rd, opc), $sformatf("random op %0h", opc));
    end
    decodeOne(encInstr(7'h00, 5'd0, 5'd1, 3'd3, 5'd2, load), "load f3 3");
    decodeOne(encInstr(7'h01, 5'd3, 5'd1, 3'd0, 5'd2, op), "op f7 01");
    decodeOne(encInstr(7'h20, 5'd3, 5'd1, 3'd1, 5'd2, op), "sll alt");
    decodeOne(encInstr(7'h40, 5'd3, 5'd1, 3'd5, 5'd2, opImm), "srai f7 40");
    decodeOne(encInstr(7'h00, 5'd0, 5'd1, 3'd1, 5'd2, jalr), "jalr f3 1");
    decodeOne(encInstr(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, 7'b1111111), "unknown");
    reportTest("decode table", errs);
  endtask

  task automatic pipelineTest();
    int errs;
    errs = errCount;
    pushThrough("addi", encInstr(7'h00, 5'd5, 5'd1, 3'd0, 5'd3, opImm),
                2'b01, 1'b0, 1'b1, 1'b0, 2'b00, 1'b1, 1'b0, 1'b0, 1'b0, resAlu);
    pushThrough("add", encInstr(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, op),
                2'b01, 1'b0, 1'b0, 1'b0, 2'b00, 1'b1, 1'b0, 1'b0, 1'b0, resAlu);
    pushThrough("sub", encInstr(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, op),
                2'b11, 1'b0, 1'b0, 1'b0, 2'b00, 1'b1, 1'b0, 1'b0, 1'b0, resAlu);
    pushThrough("srai", encInstr(7'h20, 5'd4, 5'd1, 3'd5, 5'd3, opImm),
                2'b11, 1'b0, 1'b1, 1'b0, 2'b00, 1'b1, 1'b0, 1'b0, 1'b0, resAlu);
    pushThrough("slti", encInstr(7'h00, 5'd7, 5'd1, 3'd2, 5'd3, opImm),
                2'b11, 1'b0, 1'b1, 1'b0, 2'b00, 1'b1, 1'b0, 1'b0, 1'b0, resAlu);
    pushThrough("sltu", encInstr(7'h00, 5'd2, 5'd1, 3'd3, 5'd3, op),
                2'b11, 1'b0, 1'b0, 1'b0, 2'b00, 1'b1, 1'b0, 1'b0, 1'b0, resAlu);
    pushThrough("lw", encInstr(7'h00, 5'd4, 5'd1, 3'd2, 5'd3, load),
                2'b00, 1'b0, 1'b1, 1'b0, 2'b10, 1'b1, 1'b0, 1'b0, 1'b0, resMem);
    pushThrough("sw", encInstr(7'h00, 5'd2, 5'd1, 3'd2, 5'd4, store),
                2'b00, 1'b0, 1'b1, 1'b0, 2'b01, 1'b0, 1'b0, 1'b0, 1'b0, resAlu);
    pushThrough("auipc", encInstr(7'h12, 5'd3, 5'd4, 3'd5, 5'd3, auipc),
                2'b00, 1'b1, 1'b1, 1'b0, 2'b00, 1'b1, 1'b0, 1'b0, 1'b0, resAlu);
    pushThrough("lui", encInstr(7'h2a, 5'd9, 5'd6, 3'd1, 5'd3, lui),
                2'b00, 1'b0, 1'b1, 1'b1, 2'b00, 1'b1, 1'b0, 1'b0, 1'b0, resAlu);
    reportTest("pipeline", errs);
  endtask

  task automatic branchTest();
    int errs;
    logic [2:0] f3List [0:5];
    logic [2:0] f3;
    logic       eq, lt, taken;
    errs = errCount;
    f3List = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    for (int i = 0; i < 6; i++) begin
      f3 = f3List[i];
      instrD = encInstr(7'h00, 5'd2, 5'd1, f3, 5'd0, branch);
      stepEdge();                                       // Branch now in Execute
      for (int fl = 0; fl < 4; fl++) begin
        flagsE = 2'(fl);
        {eq, lt} = 2'(fl);
        case (f3)
          3'd0: taken = eq;                             // beq
          3'd1: taken = !eq;                            // bne
          3'd4, 3'd6: taken = lt;                       // blt bltu
          default: taken = !lt;                         // bge bgeu
        endcase
        #1;
        checkEq(32'(pcSrcE), 32'(taken), $sformatf("branch f3 %0d flags %0d pcSrcE", f3, fl));
        checkEq(32'(branchSignedE), 32'(f3 < 3'd6), $sformatf("branch f3 %0d signed", f3));
        @(negedge clk);
      end
    end
    flagsE = 2'b00;
    instrD = encInstr(7'h00, 5'd0, 5'd0, 3'd0, 5'd1, jal);
    stepEdge();
    #1;
    checkEq(32'(pcSrcE), 32'd1, "jal pcSrcE");
    @(negedge clk);
    instrD = encInstr(7'h00, 5'd0, 5'd5, 3'd0, 5'd1, jalr);
    stepEdge();
    #1;
    checkEq(32'(pcSrcE), 32'd1, "jalr pcSrcE");
    @(negedge clk);
    instrD = Nop;
    reportTest("branch", errs);
  endtask

  task automatic stallFlushTest();
    int errs;
    errs = errCount;
    instrD = encInstr(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, op); // sub
    stepEdge();
    stallE = 1'b1;
    instrD = encInstr(7'h00, 5'd4, 5'd1, 3'd2, 5'd3, load);
    stepEdge();                                         // Must hold sub
    checkEq(32'(aluControlE), 32'b11, "stall aluControlE");
    checkEq(32'(aluSrcBE), 32'd0, "stall aluSrcBE");
    checkEq(32'(funct3E), 32'd0, "stall funct3E");
    checkEq(32'(instrValidE), 32'd1, "stall instrValidE");
    flushE = 1'b1;
    stepEdge();                                         // Flush while stalled
    checkEq(32'(aluControlE), 32'b11, "stalled flush aluControlE");
    checkEq(32'(instrValidE), 32'd1, "stalled flush instrValidE");
    stallE = 1'b0;
    stepEdge();
    checkEq(32'(aluControlE), 32'd0, "flush aluControlE");
    checkEq(32'(funct3E), 32'd0, "flush funct3E");
    checkEq(32'(memReadE), 32'd0, "flush memReadE");
    checkEq(32'(instrValidE), 32'd0, "flush instrValidE");
    flushE = 1'b0;
    instrD = Nop;
    stepEdge();
    reportTest("stall and flush", errs);
  endtask

  task automatic csrStoreTest();
    int errs;
    errs = errCount;
    pushThrough("csrrw", encInstr(7'h18, 5'd0, 5'd5, 3'd1, 5'd1, system),
                2'b00, 1'b0, 1'b0, 1'b0, 2'b00, 1'b1, 1'b1, 1'b1, 1'b0, resCsr);
    pushThrough("csrrs x0", encInstr(7'h18, 5'd0, 5'd0, 3'd2, 5'd1, system),
                2'b00, 1'b0, 1'b0, 1'b0, 2'b00, 1'b1, 1'b1, 1'b0, 1'b0, resCsr);
    pushThrough("csrrsi 3", encInstr(7'h18, 5'd0, 5'd3, 3'd6, 5'd1, system),
                2'b00, 1'b0, 1'b0, 1'b0, 2'b00, 1'b1, 1'b1, 1'b1, 1'b0, resCsr);
    pushThrough("csrrci 0", encInstr(7'h18, 5'd0, 5'd0, 3'd7, 5'd1, system),
                2'b00, 1'b0, 1'b0, 1'b0, 2'b00, 1'b1, 1'b1, 1'b0, 1'b0, resCsr);
    pushThrough("ecall", encInstr(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, system),
                2'b00, 1'b0, 1'b0, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0, 1'b1, resAlu);
    instrD = encInstr(7'h00, 5'd2, 5'd1, 3'd2, 5'd4, store);
    stepEdge();
    stallE = 1'b1;                                      // Keep the store in Execute
    instrD = encInstr(7'h00, 5'd4, 5'd1, 3'd2, 5'd3, load);
    #1;
    checkEq(32'(storeStallD), 32'd1, "store then load storeStallD");
    @(negedge clk);
    instrD = encInstr(7'h00, 5'd2, 5'd1, 3'd0, 5'd8, store);
    #1;
    checkEq(32'(storeStallD), 32'd1, "store then store storeStallD");
    @(negedge clk);
    instrD = encInstr(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, op);
    #1;
    checkEq(32'(storeStallD), 32'd0, "store then add storeStallD");
    @(negedge clk);
    stallE = 1'b0;
    instrD = Nop;
    stepEdge();
    reportTest("csr and store stall", errs);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    rst = 1'b1;
    instrD = Nop;
    flagsE = 2'b00;
    {stallD, flushD, stallE, flushE} = 4'b0000;
    {stallM, flushM, stallW, flushW} = 4'b0000;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    resetTest();
    decodeTableTest();
    pipelineTest();
    branchTest();
    stallFlushTest();
    csrStoreTest();
    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog for the whole run
  initial begin
    #200000;
    $display("Timeout: simulation ran past its time limit");
    $display("sim failed");
    $finish;
  end
endmodule

`default_nettype wire
